/* build.f */
rtl/bus_pkg.sv
rtl/gfx_pkg.sv
rtl/reset_release.sv
rtl/apb_port.sv
rtl/addr_decoder.sv
rtl/boot_ram.sv
rtl/gfx_regs.sv
rtl/soc_bus_top.sv
verif/tb_soc_bus.sv

/* rtl/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder #(
	parameter int BOOT_DEPTH_WORDS = 8192
) (
	input  logic hdmi_pixClk,
	input  logic rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp,
	output bus_pkg::bus_req_t boot_req,
	output bus_pkg::bus_req_t gfx_req,
	input  bus_pkg::bus_rsp_t boot_rsp,
	input  bus_pkg::bus_rsp_t gfx_rsp
);

	localparam bus_pkg::addr_t BOOT_SPAN =
		bus_pkg::addr_t'(BOOT_DEPTH_WORDS * bus_pkg::STRB_W);

	bus_pkg::region_e region;
	bus_pkg::region_e sel_q;
	bus_pkg::addr_t boot_off;
	logic gfx_hit;
	logic err_q;

	assign boot_off = req.addr - bus_pkg::BOOT_BASE;
	assign gfx_hit = (req.addr >> bus_pkg::GFX_ADDR_BITS) ==
		(bus_pkg::GFX_BASE >> bus_pkg::GFX_ADDR_BITS);

	always_comb begin
		if (req.addr >= bus_pkg::BOOT_BASE && boot_off < BOOT_SPAN)
			region = bus_pkg::REGION_BOOT;
		else if (gfx_hit)
			region = bus_pkg::REGION_GFX;
		else
			region = bus_pkg::REGION_NONE; // SDRAM window lands here too
	end

	always_comb begin
		boot_req = req;
		gfx_req = req;
		boot_req.valid = req.valid && (region == bus_pkg::REGION_BOOT);
		gfx_req.valid = req.valid && (region == bus_pkg::REGION_GFX);
	end

	// Remember the target until its response comes back
	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= bus_pkg::REGION_NONE;
			err_q <= 1'b0;
		end else begin
			err_q <= req.valid && (region == bus_pkg::REGION_NONE);
			if (req.valid)
				sel_q <= region;
		end
	end

	always_comb begin
		case (sel_q)
			bus_pkg::REGION_BOOT: rsp = boot_rsp;
			bus_pkg::REGION_GFX: rsp = gfx_rsp;
			default: rsp = '{ready: err_q, err: err_q, rdata: '0};
		endcase
	end

	// Only the selected target may answer
	a_rsp_selected: assert property (
		@(posedge hdmi_pixClk) disable iff (!rst_n)
		!(boot_rsp.ready && sel_q != bus_pkg::REGION_BOOT) &&
			!(gfx_rsp.ready && sel_q != bus_pkg::REGION_GFX)
	);

endmodule

/* rtl/apb_port.sv */
`timescale 1ns/1ps

module apb_port (
	input  logic hdmi_pixClk,
	input  logic rst_n,
	input  bus_pkg::addr_t paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  bus_pkg::word_t pwdata,
	input  bus_pkg::strb_t pstrb,
	output bus_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output bus_pkg::bus_req_t req,
	input  bus_pkg::bus_rsp_t rsp
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		DONE
	} state_e;

	state_e state;
	logic req_valid;
	logic req_write;
	bus_pkg::addr_t req_addr;
	bus_pkg::word_t req_wdata;
	bus_pkg::strb_t req_strb;

	assign req = '{
		valid: req_valid,
		write: req_write,
		addr: req_addr,
		wdata: req_wdata,
		strb: req_strb
	};

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			req_valid <= 1'b0;
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			pready <= 1'b0;
			pslverr <= 1'b0;
			case (state)
				IDLE: if (psel) begin
					state <= ISSUE;
					req_valid <= 1'b1; // One cycle pulse
				end
				ISSUE: state <= WAIT;
				WAIT: if (rsp.ready) begin
					state <= DONE;
					pready <= 1'b1;
					pslverr <= rsp.err;
				end
				default: state <= IDLE; // DONE once the requester sees completion
			endcase
		end
	end

	// Transfer fields held stable by the requester until pready
	always_ff @(posedge hdmi_pixClk) begin
		if (state == IDLE && psel) begin
			req_write <= pwrite;
			req_addr <= paddr;
			req_wdata <= pwdata;
			req_strb <= pstrb;
		end
		if (state == WAIT && rsp.ready)
			prdata <= rsp.rdata;
	end

	// Access phase always follows a setup phase
	a_setup_before_access: assert property (
		@(posedge hdmi_pixClk) disable iff (!rst_n)
		penable |-> $past(psel)
	);

endmodule

/* rtl/boot_ram.sv */
`timescale 1ns/1ps

module boot_ram #(
	parameter int BOOT_DEPTH_WORDS = 8192
) (
	input  logic hdmi_pixClk,
	input  logic rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp
);

	localparam int IDX_W = $clog2(BOOT_DEPTH_WORDS);

	bus_pkg::word_t mem [BOOT_DEPTH_WORDS];
	bus_pkg::addr_t offset;
	logic [IDX_W-1:0] idx;
	logic ready_q;
	bus_pkg::word_t rdata_q;

	assign offset = req.addr - bus_pkg::BOOT_BASE;
	assign idx = offset[IDX_W+1:2]; // Word index

	always_ff @(posedge hdmi_pixClk) begin
		if (req.valid) begin
			if (req.write) begin
				for (int b = 0; b < bus_pkg::STRB_W; b++) begin
					if (req.strb[b])
						mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
				end
			end
			rdata_q <= mem[idx]; // Old data on a write
		end
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= req.valid;
	end

	assign rsp = '{ready: ready_q, err: 1'b0, rdata: rdata_q};

	// Requester must enable at least one byte on writes
	a_write_strobe: assert property (
		@(posedge hdmi_pixClk) disable iff (!rst_n)
		(req.valid && req.write) |-> (req.strb != '0)
	);

endmodule

/* rtl/bus_pkg.sv */
package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [STRB_W-1:0] strb_t;

	// Memory map
	localparam addr_t BOOT_BASE = 32'h0201_0000;
	localparam addr_t GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8; // 256 byte register window

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_BOOT,
		REGION_GFX
	} region_e;

	typedef struct packed {
		logic valid;
		logic write;
		addr_t addr;
		word_t wdata;
		strb_t strb;
	} bus_req_t;

	typedef struct packed {
		logic ready; // Single cycle per request
		logic err;
		word_t rdata;
	} bus_rsp_t;

endpackage

/* rtl/gfx_pkg.sv */
package gfx_pkg;

	// Word index inside the register window
	typedef enum logic [5:0] {
		REG_ID = 6'd0,
		REG_CTRL = 6'd1,
		REG_FB_BASE = 6'd2,
		REG_BG_COLOR = 6'd3,
		REG_CURSOR = 6'd4
	} gfx_reg_e;

	typedef enum logic [1:0] {
		MODE_TEXT,
		MODE_RGB332,
		MODE_RGB565,
		MODE_RGB888
	} gfx_mode_e;

	localparam bus_pkg::word_t GFX_ID = 32'h4758_0001; // "GX" revision 1

	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_MODE_LSB = 1;
	localparam int BG_COLOR_W = 24;
	localparam int CURSOR_W = 11;
	localparam int CURSOR_Y_LSB = 16;

	typedef struct packed {
		logic enable;
		gfx_mode_e mode;
		bus_pkg::word_t fb_base; // Word aligned
		logic [BG_COLOR_W-1:0] bg_color;
		logic [CURSOR_W-1:0] cursor_x;
		logic [CURSOR_W-1:0] cursor_y;
	} gfx_cfg_t;

endpackage

/* rtl/gfx_regs.sv */
`timescale 1ns/1ps

module gfx_regs (
	input  logic hdmi_pixClk,
	input  logic rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp,
	output gfx_pkg::gfx_cfg_t display_cfg
);

	gfx_pkg::gfx_reg_e idx;
	gfx_pkg::gfx_cfg_t cfg_q;
	bus_pkg::word_t rd_word;
	bus_pkg::word_t rdata_q;
	logic bad;
	logic ready_q;
	logic err_q;

	assign idx = gfx_pkg::gfx_reg_e'(req.addr[bus_pkg::GFX_ADDR_BITS-1:2]);
	assign bad = (idx > gfx_pkg::REG_CURSOR) || (req.write && idx == gfx_pkg::REG_ID);

	always_comb begin
		rd_word = '0;
		case (idx)
			gfx_pkg::REG_ID: rd_word = gfx_pkg::GFX_ID;
			gfx_pkg::REG_CTRL: begin
				rd_word[gfx_pkg::CTRL_EN_BIT] = cfg_q.enable;
				rd_word[gfx_pkg::CTRL_MODE_LSB +: 2] = cfg_q.mode;
			end
			gfx_pkg::REG_FB_BASE: rd_word = cfg_q.fb_base;
			gfx_pkg::REG_BG_COLOR: rd_word[gfx_pkg::BG_COLOR_W-1:0] = cfg_q.bg_color;
			gfx_pkg::REG_CURSOR: begin
				rd_word[gfx_pkg::CURSOR_W-1:0] = cfg_q.cursor_x;
				rd_word[gfx_pkg::CURSOR_Y_LSB +: gfx_pkg::CURSOR_W] = cfg_q.cursor_y;
			end
			default: rd_word = '0;
		endcase
	end

	// Whole word writes, strobes not used
	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0;
			ready_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ready_q <= req.valid;
			err_q <= req.valid && bad;
			if (req.valid && req.write && !bad) begin
				case (idx)
					gfx_pkg::REG_CTRL: begin
						cfg_q.enable <= req.wdata[gfx_pkg::CTRL_EN_BIT];
						cfg_q.mode <= gfx_pkg::gfx_mode_e'(req.wdata[gfx_pkg::CTRL_MODE_LSB +: 2]);
					end
					gfx_pkg::REG_FB_BASE: cfg_q.fb_base <= {req.wdata[bus_pkg::DATA_W-1:2], 2'b00};
					gfx_pkg::REG_BG_COLOR: cfg_q.bg_color <= req.wdata[gfx_pkg::BG_COLOR_W-1:0];
					gfx_pkg::REG_CURSOR: begin
						cfg_q.cursor_x <= req.wdata[gfx_pkg::CURSOR_W-1:0];
						cfg_q.cursor_y <= req.wdata[gfx_pkg::CURSOR_Y_LSB +: gfx_pkg::CURSOR_W];
					end
					default: cfg_q <= cfg_q;
				endcase
			end
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (req.valid)
			rdata_q <= bad ? '0 : rd_word;
	end

	assign rsp = '{ready: ready_q, err: err_q, rdata: rdata_q};
	assign display_cfg = cfg_q;

endmodule

/* rtl/reset_release.sv */
`timescale 1ns/1ps

module reset_release #(
	parameter int RESET_HOLD = 255
) (
	input  logic hdmi_pixClk,
	input  logic arst_n,
	output logic rst_n
);

	localparam logic [7:0] HOLD = 8'(RESET_HOLD);

	logic [7:0] count;

	// Assert at once, release after the hold count
	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			rst_n <= 1'b0;
		end else begin
			if (count != HOLD)
				count <= count + 8'd1;
			rst_n <= (count == HOLD);
		end
	end

endmodule

/* rtl/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top #(
	parameter int BOOT_DEPTH_WORDS = 8192,
	parameter int RESET_HOLD = 255
) (
	input  logic hdmi_pixClk,
	input  logic arst_n,
	input  bus_pkg::addr_t paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  bus_pkg::word_t pwdata,
	input  bus_pkg::strb_t pstrb,
	output bus_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output gfx_pkg::gfx_cfg_t display_cfg
);

	logic rst_n;
	bus_pkg::bus_req_t port_req;
	bus_pkg::bus_rsp_t port_rsp;
	bus_pkg::bus_req_t boot_req;
	bus_pkg::bus_rsp_t boot_rsp;
	bus_pkg::bus_req_t gfx_req;
	bus_pkg::bus_rsp_t gfx_rsp;

	reset_release #(.RESET_HOLD(RESET_HOLD)) reset_release_i (
		.hdmi_pixClk(hdmi_pixClk),
		.arst_n(arst_n),
		.rst_n(rst_n)
	);

	apb_port apb_port_i (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.req(port_req),
		.rsp(port_rsp)
	);

	addr_decoder #(.BOOT_DEPTH_WORDS(BOOT_DEPTH_WORDS)) addr_decoder_i (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.req(port_req),
		.rsp(port_rsp),
		.boot_req(boot_req),
		.gfx_req(gfx_req),
		.boot_rsp(boot_rsp),
		.gfx_rsp(gfx_rsp)
	);

	boot_ram #(.BOOT_DEPTH_WORDS(BOOT_DEPTH_WORDS)) boot_ram_i (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.req(boot_req),
		.rsp(boot_rsp)
	);

	gfx_regs gfx_regs_i (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.req(gfx_req),
		.rsp(gfx_rsp),
		.display_cfg(display_cfg)
	);

endmodule

/* verif/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

	localparam int BOOT_WORDS = 8192;
	localparam int TIMEOUT = 1000; // Covers the 256 cycle reset hold
	localparam int NUM_WORDS = 16;

	logic hdmi_pixClk;
	logic arst_n;
	bus_pkg::addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	bus_pkg::word_t pwdata;
	bus_pkg::strb_t pstrb;
	bus_pkg::word_t prdata;
	logic pready;
	logic pslverr;
	gfx_pkg::gfx_cfg_t display_cfg;

	logic [31:0] lfsr = 32'h8af6;
	bus_pkg::word_t ram_model [int unsigned];
	gfx_pkg::gfx_cfg_t cfg_model = '0;
	bus_pkg::word_t exp_data_q [$];
	logic exp_err_q [$];
	logic is_read_q [$];
	gfx_pkg::gfx_cfg_t exp_cfg_q [$];
	int mismatch_count = 0;
	int other_count = 0;

	soc_bus_top #(.BOOT_DEPTH_WORDS(BOOT_WORDS), .RESET_HOLD(255)) dut_i (
		.hdmi_pixClk(hdmi_pixClk),
		.arst_n(arst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.display_cfg(display_cfg)
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #4 hdmi_pixClk = ~hdmi_pixClk;
	end

	// Galois form with taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Expected response from the memory map and register rules
	function automatic void ref_access(input bus_pkg::addr_t addr, input logic write,
		input bus_pkg::word_t wdata, input bus_pkg::strb_t strb,
		output bus_pkg::word_t data, output logic err);
		int unsigned widx;
		int unsigned ridx;
		data = '0;
		err = 1'b0;
		if (addr >= bus_pkg::BOOT_BASE && addr < bus_pkg::BOOT_BASE + BOOT_WORDS * 4) begin
			widx = (addr - bus_pkg::BOOT_BASE) >> 2;
			data = ram_model.exists(widx) ? ram_model[widx] : 'x;
			if (write) begin
				if (!ram_model.exists(widx))
					ram_model[widx] = '0;
				for (int b = 0; b < 4; b++)
					if (strb[b])
						ram_model[widx][b*8 +: 8] = wdata[b*8 +: 8];
			end
		end else if (addr[31:8] == bus_pkg::GFX_BASE[31:8]) begin
			ridx = addr[7:2];
			if (ridx > 4 || (write && ridx == 0)) begin
				err = 1'b1;
			end else if (write) begin
				case (ridx)
					1: begin
						cfg_model.enable = wdata[0];
						cfg_model.mode = gfx_pkg::gfx_mode_e'(wdata[2:1]);
					end
					2: cfg_model.fb_base = {wdata[31:2], 2'b00};
					3: cfg_model.bg_color = wdata[23:0];
					default: begin
						cfg_model.cursor_x = wdata[10:0];
						cfg_model.cursor_y = wdata[26:16];
					end
				endcase
			end else begin
				case (ridx)
					0: data = 32'h4758_0001;
					1: data = {29'd0, cfg_model.mode, cfg_model.enable};
					2: data = cfg_model.fb_base;
					3: data = {8'd0, cfg_model.bg_color};
					default: data = {5'd0, cfg_model.cursor_y, 5'd0, cfg_model.cursor_x};
				endcase
			end
		end else begin
			err = 1'b1; // Unmapped space including SDRAM
		end
	endfunction

	task automatic check_data(input string name, input bus_pkg::word_t exp,
		input bus_pkg::word_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_cfg(input gfx_pkg::gfx_cfg_t exp, input gfx_pkg::gfx_cfg_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH t=%0t display_cfg expected %h actual %h", $time, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic apb_transfer(input bus_pkg::addr_t addr, input logic write,
		input bus_pkg::word_t wdata, input bus_pkg::strb_t strb);
		bus_pkg::word_t exp_data;
		logic exp_err;
		int cycles;
		ref_access(addr, write, wdata, strb, exp_data, exp_err);
		exp_data_q.push_back(exp_data);
		exp_err_q.push_back(exp_err);
		is_read_q.push_back(!write);
		exp_cfg_q.push_back(cfg_model);
		@(negedge hdmi_pixClk);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		pstrb = write ? strb : '0;
		psel = 1'b1; // Setup phase
		@(negedge hdmi_pixClk);
		penable = 1'b1;
		cycles = 0;
		while (pready !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge hdmi_pixClk);
			cycles++;
		end
		psel = 1'b0;
		penable = 1'b0;
		if (pready !== 1'b1) begin
			other_count++;
			$display("Timeout: no pready within %0d cycles for address %h", TIMEOUT, addr);
			finish_run();
		end
	endtask

	// Checks every completed transfer
	always @(negedge hdmi_pixClk) begin : compare_proc
		bus_pkg::word_t exp_data;
		logic exp_err;
		logic is_read;
		if (pready === 1'b1) begin
			if (exp_err_q.size() == 0) begin
				other_count++;
				$display("pready seen at %0t with no transfer in progress", $time);
			end else begin
				exp_data = exp_data_q.pop_front();
				exp_err = exp_err_q.pop_front();
				is_read = is_read_q.pop_front();
				check_err("pslverr", exp_err, pslverr);
				if (is_read)
					check_data("prdata", exp_data, prdata);
				check_cfg(exp_cfg_q.pop_front(), display_cfg);
			end
		end
	end

	initial begin : stimulus
		int unsigned widx [NUM_WORDS];
		bus_pkg::strb_t strb;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		repeat (8) @(negedge hdmi_pixClk);
		check_err("pready", 1'b0, pready);
		check_err("pslverr", 1'b0, pslverr);
		check_cfg('0, display_cfg);
		arst_n = 1'b1;

		// Starts while the internal reset is still held
		apb_transfer(bus_pkg::GFX_BASE, 1'b0, '0, '0);

		for (int i = 0; i < NUM_WORDS; i++) begin
			widx[i] = rand_bits(13);
			apb_transfer(bus_pkg::BOOT_BASE + widx[i] * 4, 1'b1, rand_bits(32), 4'hf);
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			strb = bus_pkg::strb_t'(rand_bits(4));
			if (strb == '0)
				strb = 4'h1;
			apb_transfer(bus_pkg::BOOT_BASE + widx[i] * 4, 1'b1, rand_bits(32), strb);
		end
		for (int i = 0; i < NUM_WORDS; i++)
			apb_transfer(bus_pkg::BOOT_BASE + widx[i] * 4, 1'b0, '0, '0);

		repeat (3) begin
			for (int r = 1; r <= 4; r++) begin
				apb_transfer(bus_pkg::GFX_BASE + r * 4, 1'b1, rand_bits(32), 4'hf);
				apb_transfer(bus_pkg::GFX_BASE + r * 4, 1'b0, '0, '0);
			end
		end

		apb_transfer(bus_pkg::GFX_BASE, 1'b0, '0, '0);
		apb_transfer(bus_pkg::GFX_BASE, 1'b1, rand_bits(32), 4'hf);
		apb_transfer(bus_pkg::GFX_BASE + 5 * 4, 1'b1, rand_bits(32), 4'hf);
		apb_transfer(bus_pkg::GFX_BASE + 63 * 4, 1'b1, rand_bits(32), 4'hf);
		apb_transfer(bus_pkg::GFX_BASE + 10 * 4, 1'b0, '0, '0);

		// SDRAM window, then addresses just past each window
		apb_transfer(32'h8000_0000 + (rand_bits(20) << 2), 1'b1, rand_bits(32), 4'hf);
		apb_transfer(32'h8000_0000 + (rand_bits(20) << 2), 1'b0, '0, '0);
		apb_transfer(bus_pkg::BOOT_BASE + BOOT_WORDS * 4 + widx[0] * 4, 1'b1,
			rand_bits(32), 4'hf); // Aliases widx[0] under a short decode
		apb_transfer(bus_pkg::GFX_BASE + 32'h100, 1'b0, '0, '0);
		apb_transfer(32'h1000_0000 + (rand_bits(16) << 2), 1'b0, '0, '0);
		apb_transfer(bus_pkg::BOOT_BASE + widx[0] * 4, 1'b0, '0, '0);

		@(negedge hdmi_pixClk);
		if (exp_err_q.size() != 0) begin
			other_count++;
			$display("%0d transfers were never checked", exp_err_q.size());
		end
		finish_run();
	end

endmodule
